// ==== design/addr_unit.sv ====
`timescale 1ns/100ps

module addr_unit (
	input  logic clk,
	input  logic rst,
	input  logic i_fetch,
	input  logic i_data_load,
	input  logic i_use_hl,
	input  logic [15:0] i_hl,
	input  logic [15:0] i_pair,
	input  logic [1:0] i_pair_op,
	input  logic i_imm,
	output logic [15:0] o_addr,
	output logic [15:0] o_pair_res
);

	logic [15:0] pc;
	logic pc_advance;

	// opcode byte or immediate byte consumed
	assign pc_advance = i_data_load & (i_fetch | i_imm);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= 16'h0000;
		else if (pc_advance)
			pc <= pc + 16'd1;
	end

	assign o_addr = i_use_hl ? i_hl : pc;
	assign o_pair_res = (i_pair_op == cpu85_pkg::PAIR_DEC) ? i_pair - 16'd1 : i_pair + 16'd1;

endmodule

// ==== design/alu.sv ====
`timescale 1ns/100ps

module alu (
	input  logic [2:0] i_op,
	input  logic [7:0] i_a,
	input  logic [7:0] i_b,
	input  logic i_cy,
	output logic [7:0] o_res,
	output logic [7:0] o_flags
);

	logic sub;
	logic cin;
	logic [7:0] b_in;
	logic [8:0] sum;
	logic [4:0] half; // low nibble sum for AC
	logic carry;
	logic aux;

	assign sub = i_op inside {cpu85_pkg::ALU_SUB, cpu85_pkg::ALU_SBB, cpu85_pkg::ALU_CMP};
	// subtract as a + ~b + 1 where a borrow-in removes the +1
	assign cin = sub ? ~((i_op == cpu85_pkg::ALU_SBB) & i_cy) :
		((i_op == cpu85_pkg::ALU_ADC) & i_cy);
	assign b_in = sub ? ~i_b : i_b;
	assign sum = {1'b0, i_a} + {1'b0, b_in} + {8'd0, cin};
	assign half = {1'b0, i_a[3:0]} + {1'b0, b_in[3:0]} + {4'd0, cin};

	always_comb begin
		carry = 1'b0;
		aux = 1'b0;
		case (i_op)
			cpu85_pkg::ALU_ANA: begin
				o_res = i_a & i_b;
				aux = 1'b1;
			end
			cpu85_pkg::ALU_XRA: o_res = i_a ^ i_b;
			cpu85_pkg::ALU_ORA: o_res = i_a | i_b;
			default: begin
				o_res = sum[7:0];
				carry = sub ? ~sum[8] : sum[8]; // CY is a borrow on subtract
				aux = half[4];
			end
		endcase
		o_flags = 8'h00;
		o_flags[cpu85_pkg::FLAG_S] = o_res[7];
		o_flags[cpu85_pkg::FLAG_Z] = (o_res == 8'h00);
		o_flags[cpu85_pkg::FLAG_AC] = aux;
		o_flags[cpu85_pkg::FLAG_P] = ~^o_res; // even parity
		o_flags[cpu85_pkg::FLAG_CY] = carry;
	end

endmodule

// ==== design/bus_sequencer.sv ====
`timescale 1ns/100ps

module bus_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic i_ready,
	input  logic i_hold,
	input  logic [1:0] i_cyc_cnt,
	input  logic [cpu85_pkg::MAX_CYC-1:0] i_cyc_wr,
	input  logic i_six,
	input  logic i_halt,
	input  logic [15:0] i_addr,
	input  logic [7:0] i_wdata,
	output logic [cpu85_pkg::STATE_CNT-1:0] o_state,
	output logic [1:0] o_cyc_idx,
	output logic o_fetch,
	output logic o_ir_load,
	output logic o_data_load,
	output logic o_exec,
	output logic [7:0] o_a_hi,
	output logic [7:0] o_ad,
	output logic o_ad_oe,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_io_m_n,
	output logic o_s1,
	output logic o_s0,
	output logic o_hlda
);

	logic [cpu85_pkg::STATE_CNT-1:0] nxt_state;
	logic [cpu85_pkg::STATE_CNT-1:0] end_state; // where a finished machine cycle goes
	logic write;
	logic strobe;
	logic last;
	logic cyc_end;
	logic [2:0] status;

	assign o_fetch = (o_cyc_idx == 2'd0);
	assign write = ~o_fetch & i_cyc_wr[o_cyc_idx];
	assign last = (o_cyc_idx == i_cyc_cnt - 2'd1);
	assign strobe = o_state[cpu85_pkg::ST_T2] | o_state[cpu85_pkg::ST_TW] |
		o_state[cpu85_pkg::ST_T3];
	assign cyc_end = (o_state[cpu85_pkg::ST_T3] & ~o_fetch) |
		(o_state[cpu85_pkg::ST_T4] & ~i_six) | o_state[cpu85_pkg::ST_T6];

	// hold wins over halt and halt is re-entered when hold drops
	always_comb begin
		end_state = '0;
		if (i_hold)
			end_state[cpu85_pkg::ST_TH] = 1'b1;
		else if (last & i_halt)
			end_state[cpu85_pkg::ST_TT] = 1'b1;
		else
			end_state[cpu85_pkg::ST_T1] = 1'b1;
	end

	always_comb begin
		nxt_state = '0;
		case (1'b1)
			o_state[cpu85_pkg::ST_TR]: nxt_state[cpu85_pkg::ST_T1] = 1'b1;
			o_state[cpu85_pkg::ST_T1]: nxt_state[cpu85_pkg::ST_T2] = 1'b1;
			o_state[cpu85_pkg::ST_T2],
			o_state[cpu85_pkg::ST_TW]:
				nxt_state[i_ready ? cpu85_pkg::ST_T3 : cpu85_pkg::ST_TW] = 1'b1;
			o_state[cpu85_pkg::ST_T3]: begin
				if (o_fetch)
					nxt_state[cpu85_pkg::ST_T4] = 1'b1;
				else
					nxt_state = end_state;
			end
			o_state[cpu85_pkg::ST_T4]: begin
				if (i_six)
					nxt_state[cpu85_pkg::ST_T5] = 1'b1; // inx/dcx
				else
					nxt_state = end_state;
			end
			o_state[cpu85_pkg::ST_T5]: nxt_state[cpu85_pkg::ST_T6] = 1'b1;
			o_state[cpu85_pkg::ST_T6]: nxt_state = end_state;
			o_state[cpu85_pkg::ST_TH]: begin
				if (i_hold)
					nxt_state[cpu85_pkg::ST_TH] = 1'b1;
				else
					nxt_state[i_halt ? cpu85_pkg::ST_TT : cpu85_pkg::ST_T1] = 1'b1;
			end
			o_state[cpu85_pkg::ST_TT]:
				nxt_state[i_hold ? cpu85_pkg::ST_TH : cpu85_pkg::ST_TT] = 1'b1;
			default: nxt_state[cpu85_pkg::ST_TR] = 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_state <= '0;
			o_state[cpu85_pkg::ST_TR] <= 1'b1;
			o_cyc_idx <= 2'd0;
		end else begin
			o_state <= nxt_state;
			if (cyc_end)
				o_cyc_idx <= last ? 2'd0 : o_cyc_idx + 2'd1; // back to fetch after last
		end
	end

	assign status = o_state[cpu85_pkg::ST_TT] ? cpu85_pkg::CYC_HLT :
		o_fetch ? cpu85_pkg::CYC_OF :
		write ? cpu85_pkg::CYC_MW : cpu85_pkg::CYC_MR;
	assign {o_io_m_n, o_s1, o_s0} = status;

	assign o_ale = o_state[cpu85_pkg::ST_T1];
	assign o_rd_n = ~(strobe & ~write);
	assign o_wr_n = ~(strobe & write);
	assign o_ad_oe = o_state[cpu85_pkg::ST_T1] | (strobe & write);
	assign o_ad = o_state[cpu85_pkg::ST_T1] ? i_addr[7:0] : i_wdata; // low address, then data
	assign o_a_hi = i_addr[15:8];
	assign o_hlda = o_state[cpu85_pkg::ST_TH];

	assign o_ir_load = o_state[cpu85_pkg::ST_T3] & o_fetch;
	assign o_data_load = o_state[cpu85_pkg::ST_T3] & ~write; // fetch byte too
	assign o_exec = cyc_end & last;

endmodule

// ==== design/cpu85_pkg.sv ====
package cpu85_pkg;

	// one-hot bit positions of the T-state vector
	localparam int ST_TR = 0; // reset
	localparam int ST_T1 = 1;
	localparam int ST_T2 = 2;
	localparam int ST_T3 = 3;
	localparam int ST_T4 = 4;
	localparam int ST_T5 = 5;
	localparam int ST_T6 = 6;
	localparam int ST_TW = 7; // wait
	localparam int ST_TH = 8; // hold
	localparam int ST_TT = 9; // halt
	localparam int STATE_CNT = 10;

	// machine cycle status as {io_m_n, s1, s0}
	localparam logic [2:0] CYC_OF = 3'b011;
	localparam logic [2:0] CYC_MR = 3'b010;
	localparam logic [2:0] CYC_MW = 3'b001;
	localparam logic [2:0] CYC_HLT = 3'b000;

	localparam int MAX_CYC = 3; // fetch plus two memory cycles

	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_ADC = 3'd1;
	localparam logic [2:0] ALU_SUB = 3'd2;
	localparam logic [2:0] ALU_SBB = 3'd3;
	localparam logic [2:0] ALU_ANA = 3'd4;
	localparam logic [2:0] ALU_XRA = 3'd5;
	localparam logic [2:0] ALU_ORA = 3'd6;
	localparam logic [2:0] ALU_CMP = 3'd7;

	localparam logic [2:0] REG_B = 3'd0;
	localparam logic [2:0] REG_C = 3'd1;
	localparam logic [2:0] REG_D = 3'd2;
	localparam logic [2:0] REG_E = 3'd3;
	localparam logic [2:0] REG_H = 3'd4;
	localparam logic [2:0] REG_L = 3'd5;
	localparam logic [2:0] REG_M = 3'd6; // memory at HL
	localparam logic [2:0] REG_A = 3'd7;

	localparam int FLAG_S = 7;
	localparam int FLAG_Z = 6;
	localparam int FLAG_AC = 4;
	localparam int FLAG_P = 2;
	localparam int FLAG_CY = 0;

	// register pair operation
	localparam logic [1:0] PAIR_NONE = 2'd0;
	localparam logic [1:0] PAIR_LOAD = 2'd1;
	localparam logic [1:0] PAIR_INC = 2'd2;
	localparam logic [1:0] PAIR_DEC = 2'd3;

	typedef struct packed {
		logic [1:0] grp;
		logic [2:0] ddd; // destination or alu op
		logic [2:0] sss; // source
	} mov_view_t;

	typedef struct packed {
		logic [1:0] grp;
		logic [1:0] rp; // BC, DE, HL, SP
		logic q; // inx/dcx select
		logic [2:0] low;
	} pair_view_t;

	typedef union packed {
		mov_view_t mov;
		pair_view_t pair;
	} opcode_t;

endpackage

// ==== design/cpu85_top.sv ====
`timescale 1ns/100ps

module cpu85_top (
	input  logic clk,
	input  logic rst,
	input  logic i_ready,
	input  logic i_hold,
	input  logic [7:0] i_ad,
	output logic [7:0] o_a_hi,
	output logic [7:0] o_ad,
	output logic o_ad_oe,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_io_m_n,
	output logic o_s1,
	output logic o_s0,
	output logic o_hlda
);

	logic [1:0] cyc_cnt;
	logic [1:0] cyc_idx;
	logic [cpu85_pkg::MAX_CYC-1:0] cyc_wr;
	logic six;
	logic halt;
	logic use_hl;
	logic fetch;
	logic ir_load;
	logic data_load;
	logic exec;
	logic [2:0] dst;
	logic [2:0] src;
	logic [1:0] rp;
	logic [2:0] alu_op;
	logic alu_en;
	logic imm;
	logic [1:0] pair_op;
	logic [15:0] addr;
	logic [15:0] hl;
	logic [15:0] pair;
	logic [15:0] pair_res;
	logic [7:0] acc;
	logic [7:0] operand;
	logic [7:0] store;
	logic [7:0] alu_res;
	logic [7:0] alu_flags;
	logic cy;

	bus_sequencer i_bus_sequencer (
		.clk(clk), .rst(rst), .i_ready(i_ready), .i_hold(i_hold),
		.i_cyc_cnt(cyc_cnt), .i_cyc_wr(cyc_wr), .i_six(six), .i_halt(halt),
		.i_addr(addr), .i_wdata(store),
		.o_state(), .o_cyc_idx(cyc_idx), .o_fetch(fetch), .o_ir_load(ir_load),
		.o_data_load(data_load), .o_exec(exec),
		.o_a_hi(o_a_hi), .o_ad(o_ad), .o_ad_oe(o_ad_oe), .o_ale(o_ale),
		.o_rd_n(o_rd_n), .o_wr_n(o_wr_n), .o_io_m_n(o_io_m_n), .o_s1(o_s1),
		.o_s0(o_s0), .o_hlda(o_hlda)
	);

	instr_decoder i_instr_decoder (
		.clk(clk), .rst(rst), .i_ir_load(ir_load), .i_ad(i_ad), .i_cyc_idx(cyc_idx),
		.o_cyc_cnt(cyc_cnt), .o_cyc_wr(cyc_wr), .o_use_hl(use_hl), .o_six(six),
		.o_halt(halt), .o_dst(dst), .o_src(src), .o_rp(rp), .o_alu_op(alu_op),
		.o_alu_en(alu_en), .o_imm(imm), .o_pair_op(pair_op)
	);

	register_bank i_register_bank (
		.clk(clk), .rst(rst), .i_exec(exec), .i_data_load(data_load), .i_ad(i_ad),
		.i_cyc_idx(cyc_idx), .i_dst(dst), .i_src(src), .i_rp(rp), .i_alu_en(alu_en),
		.i_imm(imm), .i_pair_op(pair_op), .i_alu_res(alu_res), .i_alu_flags(alu_flags),
		.i_pair_res(pair_res),
		.o_acc(acc), .o_operand(operand), .o_store(store), .o_hl(hl), .o_pair(pair),
		.o_cy(cy)
	);

	alu i_alu (
		.i_op(alu_op), .i_a(acc), .i_b(operand), .i_cy(cy),
		.o_res(alu_res), .o_flags(alu_flags)
	);

	addr_unit i_addr_unit (
		.clk(clk), .rst(rst), .i_fetch(fetch), .i_data_load(data_load),
		.i_use_hl(use_hl), .i_hl(hl), .i_pair(pair), .i_pair_op(pair_op), .i_imm(imm),
		.o_addr(addr), .o_pair_res(pair_res)
	);

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
	input  logic clk,
	input  logic rst,
	input  logic i_ir_load,
	input  logic [7:0] i_ad,
	input  logic [1:0] i_cyc_idx,
	output logic [1:0] o_cyc_cnt,
	output logic [cpu85_pkg::MAX_CYC-1:0] o_cyc_wr,
	output logic o_use_hl,
	output logic o_six,
	output logic o_halt,
	output logic [2:0] o_dst,
	output logic [2:0] o_src,
	output logic [1:0] o_rp,
	output logic [2:0] o_alu_op,
	output logic o_alu_en,
	output logic o_imm,
	output logic [1:0] o_pair_op
);

	cpu85_pkg::opcode_t ir;
	logic [cpu85_pkg::MAX_CYC-1:0] hl_plan; // per cycle, address from HL

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ir <= '0; // nop
		else if (i_ir_load)
			ir <= cpu85_pkg::opcode_t'(i_ad);
	end

	always_comb begin
		o_cyc_cnt = 2'd1;
		o_cyc_wr = '0;
		hl_plan = '0;
		o_six = 1'b0;
		o_halt = 1'b0;
		o_dst = cpu85_pkg::REG_M; // no register write
		o_src = ir.mov.sss; // 110 selects bus data
		o_alu_en = 1'b0;
		o_imm = 1'b0;
		o_pair_op = cpu85_pkg::PAIR_NONE;
		case (ir.mov.grp)
			2'b01: begin
				if (ir.mov.ddd == cpu85_pkg::REG_M && ir.mov.sss == cpu85_pkg::REG_M) begin
					o_halt = 1'b1;
				end else begin
					o_dst = ir.mov.ddd;
					if (ir.mov.sss == cpu85_pkg::REG_M || ir.mov.ddd == cpu85_pkg::REG_M) begin
						o_cyc_cnt = 2'd2;
						hl_plan[1] = 1'b1;
						o_cyc_wr[1] = (ir.mov.ddd == cpu85_pkg::REG_M); // mov m,r
					end
				end
			end
			2'b10: begin
				o_alu_en = 1'b1;
				o_dst = (ir.mov.ddd == cpu85_pkg::ALU_CMP) ? cpu85_pkg::REG_M : cpu85_pkg::REG_A;
				if (ir.mov.sss == cpu85_pkg::REG_M) begin
					o_cyc_cnt = 2'd2;
					hl_plan[1] = 1'b1;
				end
			end
			2'b11: begin
				if (ir.mov.sss == 3'b110) begin // adi..cpi
					o_alu_en = 1'b1;
					o_imm = 1'b1;
					o_cyc_cnt = 2'd2;
					o_dst = (ir.mov.ddd == cpu85_pkg::ALU_CMP) ?
						cpu85_pkg::REG_M : cpu85_pkg::REG_A;
				end
			end
			default: begin
				if (ir.mov.sss == 3'b110) begin // mvi
					o_imm = 1'b1;
					o_dst = ir.mov.ddd;
					o_cyc_cnt = (ir.mov.ddd == cpu85_pkg::REG_M) ? 2'd3 : 2'd2;
					hl_plan[2] = 1'b1;
					o_cyc_wr[2] = 1'b1;
				end else if (ir.pair.low == 3'b001 && !ir.pair.q) begin // lxi
					o_imm = 1'b1;
					o_cyc_cnt = 2'd3;
					if (ir.pair.rp != 2'd3)
						o_pair_op = cpu85_pkg::PAIR_LOAD;
				end else if (ir.pair.low == 3'b011) begin // inx, dcx
					o_six = 1'b1;
					if (ir.pair.rp != 2'd3)
						o_pair_op = ir.pair.q ? cpu85_pkg::PAIR_DEC : cpu85_pkg::PAIR_INC;
				end
			end
		endcase
	end

	assign o_use_hl = hl_plan[i_cyc_idx];
	assign o_rp = ir.pair.rp;
	assign o_alu_op = ir.mov.ddd;

endmodule

// ==== design/register_bank.sv ====
`timescale 1ns/100ps

module register_bank (
	input  logic clk,
	input  logic rst,
	input  logic i_exec,
	input  logic i_data_load,
	input  logic [7:0] i_ad,
	input  logic [1:0] i_cyc_idx,
	input  logic [2:0] i_dst,
	input  logic [2:0] i_src,
	input  logic [1:0] i_rp,
	input  logic i_alu_en,
	input  logic i_imm,
	input  logic [1:0] i_pair_op,
	input  logic [7:0] i_alu_res,
	input  logic [7:0] i_alu_flags,
	input  logic [15:0] i_pair_res,
	output logic [7:0] o_acc,
	output logic [7:0] o_operand,
	output logic [7:0] o_store,
	output logic [15:0] o_hl,
	output logic [15:0] o_pair,
	output logic o_cy
);

	logic [7:0] regs [0:7]; // slot 6 holds the flags, M is never a register
	logic [7:0] hold; // data holding register
	logic lxi_load;
	logic pair_step;

	assign lxi_load = i_data_load & (i_pair_op == cpu85_pkg::PAIR_LOAD) & (i_cyc_idx != 2'd0);
	assign pair_step = i_pair_op inside {cpu85_pkg::PAIR_INC, cpu85_pkg::PAIR_DEC};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			regs <= '{default: 8'h00};
		end else begin
			if (lxi_load)
				regs[{i_rp, i_cyc_idx == 2'd1}] <= i_ad; // low byte comes first
			if (i_exec) begin
				if (i_alu_en)
					regs[cpu85_pkg::REG_M] <= i_alu_flags;
				if (pair_step) begin
					regs[{i_rp, 1'b0}] <= i_pair_res[15:8];
					regs[{i_rp, 1'b1}] <= i_pair_res[7:0];
				end else if (i_dst != cpu85_pkg::REG_M) begin
					regs[i_dst] <= i_alu_en ? i_alu_res : o_operand;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_data_load)
			hold <= i_ad;
	end

	assign o_operand = (i_src == cpu85_pkg::REG_M) ? i_ad : regs[i_src]; // memory or immediate
	assign o_store = i_imm ? hold : regs[i_src]; // mvi m writes the held byte
	assign o_acc = regs[cpu85_pkg::REG_A];
	assign o_hl = {regs[cpu85_pkg::REG_H], regs[cpu85_pkg::REG_L]};
	assign o_pair = {regs[{i_rp, 1'b0}], regs[{i_rp, 1'b1}]};
	assign o_cy = regs[cpu85_pkg::REG_M][cpu85_pkg::FLAG_CY];

endmodule

// ==== dv/cpu85_checker.sv ====
`timescale 1ns/100ps

module cpu85_checker (
	input  logic clk,
	input  logic rst,
	input  logic i_ready,
	input  logic i_six,
	input  logic [cpu85_pkg::STATE_CNT-1:0] i_state,
	input  logic i_ale,
	input  logic i_rd_n,
	input  logic i_wr_n,
	input  logic i_ad_oe,
	input  logic [7:0] i_a_hi,
	input  logic i_hlda
);

	int err_cnt = 0; // watched by the testbench top
	logic in_wait;

	// ready low in T2 or TW stretches the cycle
	assign in_wait = (i_state[cpu85_pkg::ST_T2] | i_state[cpu85_pkg::ST_TW]) & ~i_ready;

	ale_pulse: assert property (@(posedge clk) disable iff (rst) i_ale |=> !i_ale)
	else begin
		$error("ALE high for more than one clock");
		err_cnt++;
	end

	strobe_excl: assert property (@(posedge clk) disable iff (rst) !(!i_rd_n && !i_wr_n))
	else begin
		$error("read and write strobes low together");
		err_cnt++;
	end

	read_float: assert property (@(posedge clk) disable iff (rst) !i_rd_n |-> !i_ad_oe)
	else begin
		$error("AD bus driven during a read");
		err_cnt++;
	end

	wait_hold: assert property (@(posedge clk) disable iff (rst)
		in_wait |=> i_state[cpu85_pkg::ST_TW] && $stable(i_rd_n) && $stable(i_wr_n) &&
		$stable(i_a_hi))
	else begin
		$error("bus changed during a wait state");
		err_cnt++;
	end

	six_idle: assert property (@(posedge clk) disable iff (rst)
		i_state[cpu85_pkg::ST_T4] && i_six |=> (!i_ale && i_rd_n && i_wr_n) [*2])
	else begin
		$error("bus active in T5 or T6");
		err_cnt++;
	end

	hlda_float: assert property (@(posedge clk) disable iff (rst) i_hlda |-> !i_ad_oe)
	else begin
		$error("AD bus driven while HLDA is high");
		err_cnt++;
	end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic o_clk
);

	initial o_clk = 1'b0;

	always #4 o_clk = ~o_clk; // 8 ns period

endmodule

// ==== dv/tb_cpu85.sv ====
`timescale 1ns/100ps

module tb_cpu85;

	logic clk;
	logic rst;
	logic hold;
	logic ready;
	logic [7:0] rdata;
	logic [7:0] a_hi;
	logic [7:0] ad;
	logic ad_oe;
	logic ale;
	logic rd_n;
	logic wr_n;
	logic io_m_n;
	logic s1;
	logic s0;
	logic hlda;
	int stall_cnt = 0;
	logic [15:0] exp_addr [$];
	logic [7:0] exp_data [$];
	logic [7:0] m_a; // reference accumulator
	logic m_cy;
	logic [15:0] m_hl;

	logic [7:0] prog [0:39] = '{
		8'h21, 8'h00, 8'h02, // lxi h,0200
		8'h3e, 8'h5a, 8'h47, 8'h70, // mvi a,5a then mov b,a and mov m,b
		8'hc6, 8'h37, 8'h23, 8'h77, // adi 37
		8'hd6, 8'h22, 8'h23, 8'h77, // sui 22
		8'he6, 8'h3c, 8'h23, 8'h77, // ani 3c
		8'hee, 8'ha5, 8'h23, 8'h77, // xri a5
		8'hf6, 8'h42, 8'h23, 8'h77, // ori 42
		8'h80, 8'h23, 8'h77, // add b
		8'hfe, 8'h10, 8'hce, 8'h00, // cpi 10 then aci 00
		8'h23, 8'h77,
		8'h2b, 8'h2b, 8'h77, // two dcx h
		8'h76 // hlt
	};

	tb_clock i_tb_clock (.o_clk(clk));

	cpu85_top i_cpu85_top (
		.clk(clk), .rst(rst), .i_ready(ready), .i_hold(hold), .i_ad(rdata),
		.o_a_hi(a_hi), .o_ad(ad), .o_ad_oe(ad_oe), .o_ale(ale), .o_rd_n(rd_n),
		.o_wr_n(wr_n), .o_io_m_n(io_m_n), .o_s1(s1), .o_s0(s0), .o_hlda(hlda)
	);

	tb_memory i_mem (
		.clk(clk), .i_ale(ale), .i_a_hi(a_hi), .i_ad(ad), .i_rd_n(rd_n), .i_wr_n(wr_n),
		.i_status({io_m_n, s1, s0}), .o_ready(ready), .o_rdata(rdata)
	);

	bind bus_sequencer cpu85_checker i_checker (
		.clk(clk), .rst(rst), .i_ready(i_ready), .i_six(i_six), .i_state(o_state),
		.i_ale(o_ale), .i_rd_n(o_rd_n), .i_wr_n(o_wr_n), .i_ad_oe(o_ad_oe),
		.i_a_hi(o_a_hi), .i_hlda(o_hlda)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] exp,
		input logic [15:0] got);
		abort_run($sformatf("** Error: %s expected %h, got %h", name, exp, got));
	endtask

	// returns {cy, result} with cy as the borrow on subtract
	function automatic logic [8:0] alu_model(input logic [2:0] op, input logic [7:0] a,
		input logic [7:0] b, input logic cy);
		case (op)
			cpu85_pkg::ALU_ADD: return {1'b0, a} + {1'b0, b};
			cpu85_pkg::ALU_ADC: return {1'b0, a} + {1'b0, b} + {8'd0, cy};
			cpu85_pkg::ALU_SUB, cpu85_pkg::ALU_CMP: return {1'b0, a} - {1'b0, b};
			cpu85_pkg::ALU_SBB: return {1'b0, a} - {1'b0, b} - {8'd0, cy};
			cpu85_pkg::ALU_ANA: return {1'b0, a & b};
			cpu85_pkg::ALU_XRA: return {1'b0, a ^ b};
			default: return {1'b0, a | b};
		endcase
	endfunction

	task automatic apply_op(input logic [2:0] op, input logic [7:0] b);
		logic [8:0] t;
		t = alu_model(op, m_a, b, m_cy);
		m_cy = t[8];
		if (op != cpu85_pkg::ALU_CMP)
			m_a = t[7:0]; // compare touches flags only
	endtask

	task automatic expect_store(input logic [15:0] where, input logic [7:0] val);
		exp_addr.push_back(where);
		exp_data.push_back(val);
	endtask

	// stores in program order
	task automatic build_expected();
		logic [7:0] reg_b;
		m_a = 8'h5a;
		m_cy = 1'b0;
		m_hl = 16'h0200;
		reg_b = m_a;
		expect_store(m_hl, reg_b);
		apply_op(cpu85_pkg::ALU_ADD, 8'h37);
		m_hl++;
		expect_store(m_hl, m_a);
		apply_op(cpu85_pkg::ALU_SUB, 8'h22);
		m_hl++;
		expect_store(m_hl, m_a);
		apply_op(cpu85_pkg::ALU_ANA, 8'h3c);
		m_hl++;
		expect_store(m_hl, m_a);
		apply_op(cpu85_pkg::ALU_XRA, 8'ha5);
		m_hl++;
		expect_store(m_hl, m_a);
		apply_op(cpu85_pkg::ALU_ORA, 8'h42);
		m_hl++;
		expect_store(m_hl, m_a);
		apply_op(cpu85_pkg::ALU_ADD, reg_b);
		m_hl++;
		expect_store(m_hl, m_a);
		apply_op(cpu85_pkg::ALU_CMP, 8'h10);
		apply_op(cpu85_pkg::ALU_ADC, 8'h00); // carry from cpi shows up here
		m_hl++;
		expect_store(m_hl, m_a);
		m_hl = m_hl - 16'd2;
		expect_store(m_hl, m_a);
	endtask

	always @(negedge clk) begin
		if (i_cpu85_top.i_bus_sequencer.o_state[cpu85_pkg::ST_TW])
			stall_cnt++;
		if (i_cpu85_top.i_bus_sequencer.i_checker.err_cnt != 0)
			abort_run("bus protocol assertion failed");
	end

	initial begin
		int n;
		int idx;
		rst = 1'b1;
		hold = 1'b0;
		build_expected();
		@(negedge clk);
		foreach (prog[i])
			i_mem.mem[i] = prog[i];
		repeat (4) @(negedge clk);
		rst = 1'b0;

		n = 0;
		while (i_mem.wr_addr.size() < 2) begin
			@(negedge clk);
			n++;
			if (n > 1000)
				abort_run("timeout waiting for the first two stores");
		end
		hold = 1'b1; // mid-program
		n = 0;
		while (!hlda) begin
			@(negedge clk);
			n++;
			if (n > 200)
				abort_run("timeout waiting for HLDA");
		end
		repeat (4) begin
			assert (!ad_oe && !ale) else abort_run("bus driven while HLDA is high");
			@(negedge clk);
			assert (hlda) else report_mismatch("o_hlda", 16'h1, {15'd0, hlda});
		end
		hold = 1'b0;
		n = 0;
		while (!ale) begin
			@(negedge clk);
			n++;
			if (n > 20)
				abort_run("timeout waiting for the bus to resume after HOLD");
		end

		n = 0;
		while (io_m_n || s1 || s0) begin // halt status is all zero
			@(negedge clk);
			n++;
			if (n > 3000)
				abort_run("timeout waiting for HLT");
		end
		repeat (40) begin
			@(negedge clk);
			assert (!ale) else abort_run("ALE seen after HLT");
			assert (!s1 && !s0) else report_mismatch("{o_s1,o_s0}", 16'h0, {14'd0, s1, s0});
		end

		assert (stall_cnt > 0) else abort_run("READY never stretched a bus cycle");
		assert (i_mem.wr_addr.size() == exp_addr.size())
		else report_mismatch("write cycle count", 16'(exp_addr.size()),
			16'(i_mem.wr_addr.size()));
		foreach (exp_addr[i]) begin
			assert (i_mem.wr_addr[i] == exp_addr[i])
			else report_mismatch("{o_a_hi,o_ad} write address", exp_addr[i], i_mem.wr_addr[i]);
			assert (i_mem.wr_data[i] == exp_data[i])
			else report_mismatch("o_ad write data", {8'h00, exp_data[i]},
				{8'h00, i_mem.wr_data[i]});
		end

		idx = -1;
		foreach (i_mem.cyc_addr[i]) begin
			if (idx < 0 && i_mem.cyc_kind[i] == cpu85_pkg::CYC_MW &&
				i_mem.cyc_addr[i] == 16'h0200)
				idx = i;
		end
		assert (idx > 0) else abort_run("no write cycle to address 0200");
		assert (i_mem.cyc_kind[idx-1] == cpu85_pkg::CYC_OF && i_mem.cyc_addr[idx-1] == 16'h0006)
		else abort_run("write to 0200 does not follow the fetch of MOV M,B at 0006");

		if (i_cpu85_top.i_bus_sequencer.i_checker.err_cnt == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			abort_run("bus protocol assertion failed");
		end
	end

endmodule

// ==== dv/tb_memory.sv ====
`timescale 1ns/100ps

module tb_memory (
	input  logic clk,
	input  logic i_ale,
	input  logic [7:0] i_a_hi,
	input  logic [7:0] i_ad,
	input  logic i_rd_n,
	input  logic i_wr_n,
	input  logic [2:0] i_status,
	output logic o_ready,
	output logic [7:0] o_rdata
);

	logic [7:0] mem [0:65535];
	logic [15:0] addr; // latched at ALE
	logic wr_seen;
	integer seed;
	logic [15:0] cyc_addr [$]; // one entry per machine cycle
	logic [2:0] cyc_kind [$];
	logic [15:0] wr_addr [$]; // one entry per write cycle
	logic [7:0] wr_data [$];

	initial begin
		int a;
		seed = 32'hbb1b_2296;
		addr = 16'h0000;
		wr_seen = 1'b0;
		o_ready = 1'b1;
		o_rdata = 8'h00;
		for (a = 0; a < 65536; a++)
			mem[a] = a[15:8] ^ a[7:0] ^ 8'h3c; // background pattern
	end

	always @(negedge clk) begin
		if (i_ale) begin
			addr = {i_a_hi, i_ad};
			wr_seen = 1'b0;
			cyc_addr.push_back(addr);
			cyc_kind.push_back(i_status);
		end
		if (!i_rd_n)
			o_rdata <= mem[addr];
		if (!i_wr_n && !wr_seen) begin
			mem[addr] = i_ad;
			wr_addr.push_back(addr);
			wr_data.push_back(i_ad);
			wr_seen = 1'b1; // log once per cycle
		end
		o_ready <= ($random(seed) & 3) != 0; // stall about one sample in four
	end

endmodule

// ==== list.f ====
design/cpu85_pkg.sv
design/bus_sequencer.sv
design/instr_decoder.sv
design/register_bank.sv
design/alu.sv
design/addr_unit.sv
design/cpu85_top.sv
dv/tb_clock.sv
dv/tb_memory.sv
dv/cpu85_checker.sv
dv/tb_cpu85.sv
